// ==== design/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;    // Data word or byte address
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  regno_t;
    typedef logic [15:0] imm_t;     // Sign-extended in decode
    typedef logic [5:0]  op1_t;
    typedef logic [7:0]  op2_t;
    typedef logic [1:0]  alu_src_t;
    typedef logic [1:0]  wb_src_t;

    // Primary opcodes
    localparam op1_t OP1_ALUR = 6'b000000;
    localparam op1_t OP1_BEQ  = 6'b001000;
    localparam op1_t OP1_BLT  = 6'b001001;
    localparam op1_t OP1_BLE  = 6'b001010;
    localparam op1_t OP1_BNE  = 6'b001011;
    localparam op1_t OP1_JAL  = 6'b001100;
    localparam op1_t OP1_LW   = 6'b010010;
    localparam op1_t OP1_SW   = 6'b011010;
    localparam op1_t OP1_ADDI = 6'b100000;
    localparam op1_t OP1_ANDI = 6'b100100;
    localparam op1_t OP1_ORI  = 6'b100101;
    localparam op1_t OP1_XORI = 6'b100110;

    // Secondary opcodes of the ALUR group
    localparam op2_t OP2_EQ   = 8'b00001000;
    localparam op2_t OP2_LT   = 8'b00001001;
    localparam op2_t OP2_LE   = 8'b00001010;
    localparam op2_t OP2_NE   = 8'b00001011;
    localparam op2_t OP2_ADD  = 8'b00100000;
    localparam op2_t OP2_AND  = 8'b00100100;
    localparam op2_t OP2_OR   = 8'b00100101;
    localparam op2_t OP2_XOR  = 8'b00100110;
    localparam op2_t OP2_SUB  = 8'b00101000;
    localparam op2_t OP2_NAND = 8'b00101100;
    localparam op2_t OP2_NOR  = 8'b00101101;
    localparam op2_t OP2_NXOR = 8'b00101110;
    localparam op2_t OP2_RSHF = 8'b00110000;
    localparam op2_t OP2_LSHF = 8'b00110001;

    // Field positions
    localparam int OP1_HI = 31;
    localparam int OP1_LO = 26;
    localparam int OP2_HI = 25;
    localparam int OP2_LO = 18;
    localparam int IMM_HI = 23;
    localparam int IMM_LO = 8;
    localparam int RD_HI  = 11;
    localparam int RD_LO  = 8;
    localparam int RS_HI  = 7;
    localparam int RS_LO  = 4;
    localparam int RT_HI  = 3;
    localparam int RT_LO  = 0;

    localparam alu_src_t ALU_SRC_RT   = 2'd0;
    localparam alu_src_t ALU_SRC_IMM  = 2'd1;
    localparam alu_src_t ALU_SRC_IMM4 = 2'd2;   // Immediate times four

    localparam wb_src_t WB_PC  = 2'd0;
    localparam wb_src_t WB_MEM = 2'd1;
    localparam wb_src_t WB_ALU = 2'd2;

    // ALUR with an unused op2, decodes to no write
    localparam inst_t BUBBLE = '0;

endpackage

// ==== design/soc_pkg.sv ====
package soc_pkg;

    localparam isa_pkg::word_t START_PC  = 32'h0000_0100;
    localparam isa_pkg::word_t INST_SIZE = 32'd4;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;
    typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_addr_t;

    // Word index taken from byte address bits 9..2
    localparam int IDX_HI = 9;
    localparam int IDX_LO = 2;

    localparam isa_pkg::word_t ADDR_HEX  = 32'hFFFF_F000;
    localparam isa_pkg::word_t ADDR_LEDR = 32'hFFFF_F020;
    localparam isa_pkg::word_t ADDR_KEY  = 32'hFFFF_F080;

    typedef logic [23:0] hex_t;
    typedef logic [9:0]  ledr_t;
    typedef logic [3:0]  key_t;

    localparam hex_t HEX_RESET = 24'hFEDEAD;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                redirect,
    input  isa_pkg::word_t      target,
    input  logic                prog_we,
    input  soc_pkg::imem_addr_t prog_addr,
    input  isa_pkg::inst_t      prog_data,
    output isa_pkg::inst_t      inst,
    output isa_pkg::word_t      pc_next
);
    import isa_pkg::*;
    import soc_pkg::*;

    inst_t      imem [IMEM_WORDS];
    word_t      pc;
    word_t      pc_inc;
    imem_addr_t fetch_idx;

    assign pc_inc    = pc + INST_SIZE;
    assign fetch_idx = pc[IDX_HI:IDX_LO];

    // Program load port, used while the core is held in reset
    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr] <= prog_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= START_PC;
        else if (redirect)          // Taken branch or JAL beats stall
            pc <= target;
        else if (!stall)
            pc <= pc_inc;
    end

    // Fetch latch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inst    <= BUBBLE;
            pc_next <= '0;
        end else if (redirect) begin
            inst    <= BUBBLE;      // Wrong-path instruction dropped
        end else if (!stall) begin
            inst    <= imem[fetch_idx];
            pc_next <= pc_inc;
        end
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic            clk,
    input  logic            reset,
    input  isa_pkg::regno_t rs,
    input  isa_pkg::regno_t rt,
    output isa_pkg::word_t  rs_val,
    output isa_pkg::word_t  rt_val,
    input  logic            wb_we,
    input  isa_pkg::regno_t wb_reg,
    input  isa_pkg::word_t  wb_data
);
    import isa_pkg::*;

    word_t regs [2**$bits(regno_t)];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**$bits(regno_t); i++)
                regs[i] <= '0;
        end else if (wb_we) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-through so writeback never needs an interlock
    assign rs_val = (wb_we && wb_reg == rs) ? wb_data : regs[rs];
    assign rt_val = (wb_we && wb_reg == rt) ? wb_data : regs[rt];

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::inst_t    inst,
    input  isa_pkg::word_t    pc_next,
    input  logic              redirect,
    input  isa_pkg::regno_t   ex_dst,
    input  logic              ex_we,
    output logic              stall,
    output isa_pkg::regno_t   rs,
    output isa_pkg::regno_t   rt,
    input  isa_pkg::word_t    rs_val,
    input  isa_pkg::word_t    rt_val,
    output isa_pkg::op1_t     d_op1,
    output isa_pkg::op2_t     d_op2,
    output isa_pkg::word_t    d_pc,
    output isa_pkg::word_t    d_a,
    output isa_pkg::word_t    d_b,
    output isa_pkg::word_t    d_imm,
    output isa_pkg::alu_src_t d_alu_src,
    output isa_pkg::wb_src_t  d_wb_src,
    output isa_pkg::regno_t   d_dst,
    output logic              d_we,
    output logic              d_mem_we
);
    import isa_pkg::*;

    op1_t     op1;
    op2_t     op2;
    imm_t     imm;
    regno_t   rd;
    alu_src_t alu_src;
    wb_src_t  wb_src;
    logic     we;
    logic     mem_we;
    logic     use_rd;
    logic     use_rt;       // rt is a source operand
    logic     rs_hazard;
    logic     rt_hazard;

    assign op1 = inst[OP1_HI:OP1_LO];
    assign op2 = inst[OP2_HI:OP2_LO];
    assign imm = inst[IMM_HI:IMM_LO];
    assign rd  = inst[RD_HI:RD_LO];
    assign rs  = inst[RS_HI:RS_LO];
    assign rt  = inst[RT_HI:RT_LO];

    always_comb begin
        alu_src = ALU_SRC_RT;
        wb_src  = WB_ALU;
        we      = 1'b0;
        mem_we  = 1'b0;
        use_rd  = 1'b0;
        use_rt  = 1'b0;
        case (op1)
            OP1_ALUR: begin
                use_rd = 1'b1;
                use_rt = 1'b1;
                // Unknown op2 (and the bubble) writes nothing
                we = op2 inside {OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND,
                                 OP2_OR, OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR,
                                 OP2_NXOR, OP2_RSHF, OP2_LSHF};
            end
            OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: use_rt = 1'b1;
            OP1_JAL: begin
                alu_src = ALU_SRC_IMM4;
                wb_src  = WB_PC;    // Link register gets pc_next
                we      = 1'b1;
            end
            OP1_LW: begin
                alu_src = ALU_SRC_IMM;
                wb_src  = WB_MEM;
                we      = 1'b1;
            end
            OP1_SW: begin
                alu_src = ALU_SRC_IMM;
                mem_we  = 1'b1;
                use_rt  = 1'b1;     // Store data
            end
            OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
                alu_src = ALU_SRC_IMM;
                we      = 1'b1;
            end
            default: ;
        endcase
    end

    // Only writers still ahead of writeback can hazard
    assign rs_hazard = (d_we && d_dst == rs) || (ex_we && ex_dst == rs);
    assign rt_hazard = use_rt && ((d_we && d_dst == rt) || (ex_we && ex_dst == rt));
    assign stall     = rs_hazard || rt_hazard;

    // Decode latch control, bubble on flush or stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_op1    <= OP1_ALUR;
            d_we     <= 1'b0;
            d_mem_we <= 1'b0;
        end else if (redirect || stall) begin
            d_op1    <= OP1_ALUR;
            d_we     <= 1'b0;
            d_mem_we <= 1'b0;
        end else begin
            d_op1    <= op1;
            d_we     <= we;
            d_mem_we <= mem_we;
        end
    end

    always_ff @(posedge clk) begin
        d_op2     <= op2;
        d_pc      <= pc_next;
        d_a       <= rs_val;
        d_b       <= rt_val;
        d_imm     <= {{($bits(word_t) - $bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};
        d_alu_src <= alu_src;
        d_wb_src  <= wb_src;
        d_dst     <= use_rd ? rd : rt;
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::op1_t     d_op1,
    input  isa_pkg::op2_t     d_op2,
    input  isa_pkg::word_t    d_pc,
    input  isa_pkg::word_t    d_a,
    input  isa_pkg::word_t    d_b,
    input  isa_pkg::word_t    d_imm,
    input  isa_pkg::alu_src_t d_alu_src,
    input  isa_pkg::wb_src_t  d_wb_src,
    input  isa_pkg::regno_t   d_dst,
    input  logic              d_we,
    input  logic              d_mem_we,
    output logic              redirect,
    output isa_pkg::word_t    target,
    output isa_pkg::word_t    e_alu,
    output isa_pkg::word_t    e_store,
    output isa_pkg::word_t    e_pc,
    output isa_pkg::regno_t   e_dst,
    output logic              e_we,
    output logic              e_mem_we,
    output isa_pkg::wb_src_t  e_wb_src
);
    import isa_pkg::*;

    word_t b;
    word_t alu;
    word_t imm4;
    logic  taken;

    assign imm4 = d_imm << 2;

    always_comb begin
        case (d_alu_src)
            ALU_SRC_IMM:  b = d_imm;
            ALU_SRC_IMM4: b = imm4;
            default:      b = d_b;
        endcase
    end

    always_comb begin
        case (d_op1)
            OP1_ALUR: begin
                case (d_op2)
                    OP2_EQ:   alu = {31'b0, d_a == b};
                    OP2_LT:   alu = {31'b0, $signed(d_a) < $signed(b)};
                    OP2_LE:   alu = {31'b0, $signed(d_a) <= $signed(b)};
                    OP2_NE:   alu = {31'b0, d_a != b};
                    OP2_ADD:  alu = d_a + b;
                    OP2_AND:  alu = d_a & b;
                    OP2_OR:   alu = d_a | b;
                    OP2_XOR:  alu = d_a ^ b;
                    OP2_SUB:  alu = d_a - b;
                    OP2_NAND: alu = ~(d_a & b);
                    OP2_NOR:  alu = ~(d_a | b);
                    OP2_NXOR: alu = ~(d_a ^ b);
                    OP2_RSHF: alu = $signed(d_a) >>> b[4:0];   // Arithmetic
                    OP2_LSHF: alu = d_a << b[4:0];
                    default:  alu = '0;
                endcase
            end
            OP1_ANDI: alu = d_a & b;
            OP1_ORI:  alu = d_a | b;
            OP1_XORI: alu = d_a ^ b;
            default:  alu = d_a + b;    // ADDI and load/store address
        endcase
    end

    always_comb begin
        case (d_op1)
            OP1_BEQ: taken = d_a == d_b;
            OP1_BLT: taken = $signed(d_a) < $signed(d_b);
            OP1_BLE: taken = $signed(d_a) <= $signed(d_b);
            OP1_BNE: taken = d_a != d_b;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken || (d_op1 == OP1_JAL);
    assign target   = (d_op1 == OP1_JAL) ? d_a + imm4 : d_pc + imm4;

    // Execute latch, never flushed so JAL reaches writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            e_we     <= 1'b0;
            e_mem_we <= 1'b0;
        end else begin
            e_we     <= d_we;
            e_mem_we <= d_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        e_alu    <= alu;
        e_store  <= d_b;
        e_pc     <= d_pc;
        e_dst    <= d_dst;
        e_wb_src <= d_wb_src;
    end

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::word_t   e_alu,
    input  isa_pkg::word_t   e_store,
    input  isa_pkg::word_t   e_pc,
    input  isa_pkg::regno_t  e_dst,
    input  logic             e_we,
    input  logic             e_mem_we,
    input  isa_pkg::wb_src_t e_wb_src,
    input  soc_pkg::key_t    key,
    output soc_pkg::hex_t    hex,
    output soc_pkg::ledr_t   ledr,
    output logic             wb_we,
    output isa_pkg::regno_t  wb_reg,
    output isa_pkg::word_t   wb_data
);
    import isa_pkg::*;
    import soc_pkg::*;

    word_t      dmem [DMEM_WORDS];
    dmem_addr_t idx;
    logic       is_io;
    word_t      load_data;

    assign idx   = e_alu[IDX_HI:IDX_LO];
    assign is_io = (e_alu == ADDR_HEX) || (e_alu == ADDR_LEDR) || (e_alu == ADDR_KEY);

    always_ff @(posedge clk) begin
        if (e_mem_we && !is_io)
            dmem[idx] <= e_store;
    end

    // Keys are active low on the board
    assign load_data = (e_alu == ADDR_KEY) ?
                       {{($bits(word_t) - $bits(key_t)){1'b0}}, ~key} : dmem[idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hex  <= HEX_RESET;
            ledr <= '0;
        end else if (e_mem_we) begin
            if (e_alu == ADDR_HEX)
                hex <= e_store[$bits(hex_t)-1:0];
            if (e_alu == ADDR_LEDR)
                ledr <= e_store[$bits(ledr_t)-1:0];
        end
    end

    // Writeback latch
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            wb_we <= 1'b0;
        else
            wb_we <= e_we;
    end

    always_ff @(posedge clk) begin
        wb_reg <= e_dst;
        case (e_wb_src)
            WB_PC:   wb_data <= e_pc;
            WB_MEM:  wb_data <= load_data;
            default: wb_data <= e_alu;
        endcase
    end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                clk,
    input  logic                reset,
    input  soc_pkg::key_t       key,
    input  logic                prog_we,
    input  soc_pkg::imem_addr_t prog_addr,
    input  isa_pkg::inst_t      prog_data,
    output soc_pkg::hex_t       hex,
    output soc_pkg::ledr_t      ledr
);
    import isa_pkg::*;

    // Fetch to decode
    inst_t    inst;
    word_t    pc_next;
    logic     stall;
    logic     redirect;
    word_t    target;

    // Register file ports
    regno_t   rs;
    regno_t   rt;
    word_t    rs_val;
    word_t    rt_val;
    logic     wb_we;
    regno_t   wb_reg;
    word_t    wb_data;

    // Decode latch
    op1_t     d_op1;
    op2_t     d_op2;
    word_t    d_pc;
    word_t    d_a;
    word_t    d_b;
    word_t    d_imm;
    alu_src_t d_alu_src;
    wb_src_t  d_wb_src;
    regno_t   d_dst;
    logic     d_we;
    logic     d_mem_we;

    // Execute latch
    word_t    e_alu;
    word_t    e_store;
    word_t    e_pc;
    regno_t   e_dst;
    logic     e_we;
    logic     e_mem_we;
    wb_src_t  e_wb_src;

    fetch_unit i_fetch_unit (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
        .target(target), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .inst(inst), .pc_next(pc_next)
    );

    reg_file i_reg_file (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt), .rs_val(rs_val), .rt_val(rt_val),
        .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    decode_stage i_decode_stage (
        .clk(clk), .reset(reset), .inst(inst), .pc_next(pc_next), .redirect(redirect),
        .ex_dst(e_dst), .ex_we(e_we), .stall(stall), .rs(rs), .rt(rt),
        .rs_val(rs_val), .rt_val(rt_val), .d_op1(d_op1), .d_op2(d_op2), .d_pc(d_pc),
        .d_a(d_a), .d_b(d_b), .d_imm(d_imm), .d_alu_src(d_alu_src),
        .d_wb_src(d_wb_src), .d_dst(d_dst), .d_we(d_we), .d_mem_we(d_mem_we)
    );

    execute_stage i_execute_stage (
        .clk(clk), .reset(reset), .d_op1(d_op1), .d_op2(d_op2), .d_pc(d_pc),
        .d_a(d_a), .d_b(d_b), .d_imm(d_imm), .d_alu_src(d_alu_src),
        .d_wb_src(d_wb_src), .d_dst(d_dst), .d_we(d_we), .d_mem_we(d_mem_we),
        .redirect(redirect), .target(target), .e_alu(e_alu), .e_store(e_store),
        .e_pc(e_pc), .e_dst(e_dst), .e_we(e_we), .e_mem_we(e_mem_we),
        .e_wb_src(e_wb_src)
    );

    mem_stage i_mem_stage (
        .clk(clk), .reset(reset), .e_alu(e_alu), .e_store(e_store), .e_pc(e_pc),
        .e_dst(e_dst), .e_we(e_we), .e_mem_we(e_mem_we), .e_wb_src(e_wb_src),
        .key(key), .hex(hex), .ledr(ledr), .wb_we(wb_we), .wb_reg(wb_reg),
        .wb_data(wb_data)
    );

endmodule

// ==== testbench/cpu_sva.sv ====
`timescale 1ns/1ps

module cpu_sva (
    input logic             clk,
    input logic             reset,
    input soc_pkg::hex_t    hex,
    input soc_pkg::ledr_t   ledr,
    input logic             stall,
    input logic             redirect,
    input logic             d_we,
    input isa_pkg::word_t   pc
);

    assert property (@(posedge clk) disable iff (reset) !$isunknown({hex, ledr}))
        else $error("hex or ledr unknown");

    // Interlock freezes fetch
    assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect) |=> pc == $past(pc))
        else $error("PC moved during stall");

    assert property (@(posedge clk) disable iff (reset) redirect |=> !d_we)
        else $error("Decode latch not flushed after redirect");

endmodule

bind cpu_top cpu_sva i_cpu_sva (
    .clk(clk), .reset(reset), .hex(hex), .ledr(ledr), .stall(stall),
    .redirect(redirect), .d_we(d_we), .pc(i_fetch_unit.pc)
);

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import isa_pkg::*;
    import soc_pkg::*;

    localparam int LOAD_BASE   = 64;    // Word index of address 100
    localparam int WAIT_LIMIT  = 100;
    // Six program runs of under 140 cycles each, with margin
    localparam int CYCLE_LIMIT = 2000;

    logic       clk;
    logic       reset;
    key_t       key;
    logic       prog_we;
    imem_addr_t prog_addr;
    inst_t      prog_data;
    hex_t       hex;
    ledr_t      ledr;

    inst_t prog [$];
    int    cycles = 0;

    cpu_top i_cpu_top (
        .clk(clk), .reset(reset), .key(key), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .hex(hex), .ledr(ledr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            fail_run("Run exceeded its cycle limit");
    end

    function automatic inst_t alur_inst(op2_t op2, regno_t rd, regno_t rs, regno_t rt);
        return {OP1_ALUR, op2, 6'b0, rd, rs, rt};
    endfunction

    // Also used for branches, loads, stores and JAL
    function automatic inst_t imm_inst(op1_t op1, regno_t rt, regno_t rs, imm_t imm);
        return {op1, 2'b0, imm, rs, rt};
    endfunction

    function automatic word_t sext(imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Reset, load prog[] while in reset, release and wait for an output change
    task automatic run_program();
        int n;
        @(posedge clk);
        reset <= 1'b1;
        prog.push_back(imm_inst(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));   // Halt loop
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= imem_addr_t'(LOAD_BASE + i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        n = 0;
        @(negedge clk);
        while (hex == HEX_RESET && ledr == '0) begin
            n++;
            if (n > WAIT_LIMIT)
                fail_run("No change on hex or ledr within the wait limit");
            @(negedge clk);
        end
        prog.delete();
    endtask

    task automatic reset_state();
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("hex", word_t'(hex), word_t'(HEX_RESET));
        check_value("ledr", word_t'(ledr), '0);
    endtask

    task automatic alu_chain();
        imm_t  i1;
        imm_t  i2;
        imm_t  sh;
        word_t r1, r2, r3, r4, r5, r6, r8, r9, r10;
        i1 = imm_t'($urandom);
        i2 = imm_t'($urandom);
        sh = imm_t'($urandom_range(0, 31));
        prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd0, i1));
        prog.push_back(imm_inst(OP1_ADDI, 4'd2, 4'd1, i2));
        prog.push_back(alur_inst(OP2_SUB, 4'd3, 4'd2, 4'd1));
        prog.push_back(alur_inst(OP2_NAND, 4'd4, 4'd3, 4'd2));
        prog.push_back(alur_inst(OP2_NXOR, 4'd5, 4'd4, 4'd1));
        prog.push_back(imm_inst(OP1_ADDI, 4'd7, 4'd0, sh));
        prog.push_back(alur_inst(OP2_RSHF, 4'd6, 4'd5, 4'd7));
        prog.push_back(alur_inst(OP2_LSHF, 4'd8, 4'd6, 4'd7));
        prog.push_back(alur_inst(OP2_LT, 4'd9, 4'd8, 4'd5));
        prog.push_back(alur_inst(OP2_XOR, 4'd10, 4'd8, 4'd9));
        prog.push_back(imm_inst(OP1_SW, 4'd10, 4'd0, 16'hF000));
        r1  = sext(i1);
        r2  = r1 + sext(i2);
        r3  = r2 - r1;
        r4  = ~(r3 & r2);
        r5  = ~(r4 ^ r1);
        r6  = $signed(r5) >>> sh[4:0];   // Arithmetic right shift
        r8  = r6 << sh[4:0];
        r9  = ($signed(r8) < $signed(r5)) ? 32'd1 : 32'd0;
        r10 = r8 ^ r9;
        run_program();
        check_value("hex", word_t'(hex), {8'b0, r10[23:0]});
    endtask

    task automatic load_store();
        word_t w;
        key_t  k;
        w = $urandom;
        w[15] = 1'b0;                   // ORI sign-extends its immediate
        if (w[9:0] == 10'h3FF)
            w[0] = 1'b0;
        prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd0, w[31:16]));
        prog.push_back(imm_inst(OP1_ADDI, 4'd2, 4'd0, 16'd16));
        prog.push_back(alur_inst(OP2_LSHF, 4'd1, 4'd1, 4'd2));
        prog.push_back(imm_inst(OP1_ORI, 4'd1, 4'd1, w[15:0]));
        prog.push_back(imm_inst(OP1_SW, 4'd1, 4'd0, 16'h0040));
        prog.push_back(imm_inst(OP1_LW, 4'd4, 4'd0, 16'h0040));
        prog.push_back(imm_inst(OP1_ADDI, 4'd4, 4'd4, 16'd1));
        prog.push_back(imm_inst(OP1_SW, 4'd4, 4'd0, 16'hF020));
        run_program();
        check_value("ledr", word_t'(ledr), word_t'(ledr_t'(w + 1)));
        k = key_t'($urandom_range(0, 14));  // All keys up would read zero
        @(posedge clk);
        key <= k;
        prog.push_back(imm_inst(OP1_LW, 4'd1, 4'd0, 16'hF080));
        prog.push_back(imm_inst(OP1_SW, 4'd1, 4'd0, 16'hF020));
        run_program();
        check_value("ledr", word_t'(ledr), {28'b0, ~k});
    endtask

    task automatic branch_skip();
        prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd0, 16'd5));
        prog.push_back(imm_inst(OP1_ADDI, 4'd2, 4'd0, 16'd3));
        prog.push_back(imm_inst(OP1_ADDI, 4'd3, 4'd0, 16'h0111));   // Wrong value
        prog.push_back(imm_inst(OP1_ADDI, 4'd4, 4'd0, 16'h0222));
        prog.push_back(imm_inst(OP1_BEQ, 4'd0, 4'd0, 16'd2));
        prog.push_back(imm_inst(OP1_SW, 4'd3, 4'd0, 16'hF000));
        prog.push_back(imm_inst(OP1_SW, 4'd3, 4'd0, 16'hF000));
        prog.push_back(imm_inst(OP1_BLT, 4'd2, 4'd1, 16'd2));    // 5 < 3 is false
        prog.push_back(imm_inst(OP1_SW, 4'd4, 4'd0, 16'hF000));
        prog.push_back(imm_inst(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));
        prog.push_back(imm_inst(OP1_SW, 4'd3, 4'd0, 16'hF000));
        run_program();
        check_value("hex", word_t'(hex), 32'h222);
    endtask

    task automatic countdown_loop();
        int count;
        int step;
        count = $urandom_range(2, 9);
        step  = $urandom_range(1, 255);
        prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd0, imm_t'(count)));
        prog.push_back(imm_inst(OP1_ADDI, 4'd2, 4'd0, imm_t'(step)));
        prog.push_back(alur_inst(OP2_ADD, 4'd3, 4'd3, 4'd2));
        prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd1, 16'hFFFF));
        prog.push_back(imm_inst(OP1_BNE, 4'd0, 4'd1, 16'hFFFD));  // Back two
        prog.push_back(imm_inst(OP1_SW, 4'd3, 4'd0, 16'hF000));
        run_program();
        check_value("hex", word_t'(hex), word_t'(count * step));
    endtask

    task automatic jal_link();
        prog.push_back(imm_inst(OP1_JAL, 4'd5, 4'd0, 16'h0048));  // To address 120
        for (int i = 1; i < 8; i++)
            prog.push_back(imm_inst(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));
        prog.push_back(imm_inst(OP1_SW, 4'd5, 4'd0, 16'hF020));
        run_program();
        check_value("ledr", word_t'(ledr), 32'h104);
    endtask

    initial begin
        reset       <= 1'b1;
        key         <= '0;
        prog_we     <= 1'b0;
        prog_addr   <= '0;
        prog_data   <= '0;
        void'($urandom(34));
        reset_state();
        alu_chain();
        load_store();
        branch_skip();
        countdown_loop();
        jal_link();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
design/isa_pkg.sv
design/soc_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/cpu_top.sv
testbench/cpu_sva.sv
testbench/cpu_tb.sv

// ==== Makefile ====
TOP = cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@grep -q "Test passed" sim.log || (echo "Simulation did not finish"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
